// ==== hdl/cpld_rx_config.svh ====
// ==========================================================
// width and count macros for the cpld receive demultiplexer
// beat data, tag, dword count and destination count
// ==========================================================

`ifndef CPLD_RX_CONFIG_SVH
`define CPLD_RX_CONFIG_SVH

// ==========================================================
// beat fields
// ==========================================================

`define CPLD_DATA_W     64  // two dwords per beat
`define CPLD_TAG_W      8   // pcie tag field
`define CPLD_DCNT_W     12  // dword count of the completion

// ==========================================================
// routing
// ==========================================================

// dfk, uek and dpk classes, two channels each
`define CPLD_DEST_NUM   6

`endif

// ==== hdl/cpld_beat_pkg.sv ====
// ==========================================================
// beat field types of one cpld beat
// packed tag union with host and kernel views
// ==========================================================

`default_nettype none

`include "cpld_rx_config.svh"

package cpld_beat_pkg;

    typedef logic [`CPLD_DATA_W-1:0] data_t;  // one beat of payload
    typedef logic [`CPLD_TAG_W-1:0]  tag_t;   // completion tag
    typedef logic [`CPLD_DCNT_W-1:0] dcnt_t;  // dword count

    // ==========================================================
    // tag views
    // ==========================================================

    // host class tags, 1Yxxxxxx
    typedef struct packed {
        logic                   dpk;   // class flag, set for dpk
        logic                   chan;  // channel 0 or 1
        logic [`CPLD_TAG_W-3:0] idx;   // request index
    } tag_host_t;

    // kernel class tags, 0Y?Dxxxx
    typedef struct packed {
        logic                   dpk;   // class flag, clear here
        logic                   chan;  // channel 0 or 1
        logic                   rsvd;  // not decoded
        logic                   dfk;   // 1 for dfk, 0 for uek
        logic [`CPLD_TAG_W-5:0] idx;   // request index
    } tag_kernel_t;

    // the same tag word read in two ways, chosen by the dpk flag
    typedef union packed {
        tag_host_t   host_view;
        tag_kernel_t kernel_view;
    } cpld_tag_u;

endpackage

`default_nettype wire

// ==== hdl/cpld_route_pkg.sv ====
// ==========================================================
// destination enumeration of the cpld demultiplexer
// destination select vector type
// ==========================================================

`default_nettype none

`include "cpld_rx_config.svh"

package cpld_route_pkg;

    // ==========================================================
    // destinations
    // ==========================================================

    // values double as bit positions in dest_sel_t
    typedef enum logic [$clog2(`CPLD_DEST_NUM)-1:0] {
        DFK_C0 = 0,  // kernel read, channel 0
        DFK_C1 = 1,  // kernel read, channel 1
        UEK_C0 = 2,  // kernel read, channel 0
        UEK_C1 = 3,  // kernel read, channel 1
        DPK_C0 = 4,  // host read, channel 0
        DPK_C1 = 5   // host read, channel 1
    } dest_e;

    // ==========================================================
    // select vector
    // ==========================================================

    // one bit per destination, one-hot once a sop was seen
    typedef logic [`CPLD_DEST_NUM-1:0] dest_sel_t;

endpackage

`default_nettype wire

// ==== hdl/cpld_stream_if.sv ====
// ==========================================================
// registered cpld beat between the swap stage and the ports
// ==========================================================

`default_nettype none

interface cpld_stream_if;

    logic                  sop;   // start of packet
    logic                  eop;   // end of packet
    logic                  dvld;  // data valid
    cpld_beat_pkg::data_t  data;  // dword swapped payload
    cpld_beat_pkg::tag_t   tag;
    cpld_beat_pkg::dcnt_t  dcnt;

    // driven by the input register stage
    modport src (
        output sop, eop, dvld, data, tag, dcnt
    );

    // read by every destination port
    modport sink (
        input sop, eop, dvld, data, tag, dcnt
    );

endinterface

`default_nettype wire

// ==== hdl/cpld_dword_swap.sv ====
// ==========================================================
// input register stage of the cpld demultiplexer
// byte reversal inside each 32-bit dword of the data
// ==========================================================

`default_nettype none

`include "cpld_rx_config.svh"

module cpld_dword_swap (
    input  logic                 PCIE_CLK,
    input  logic                 PCIE_RST,
    input  logic                 in_sop,
    input  logic                 in_eop,
    input  logic                 in_dvld,
    input  cpld_beat_pkg::data_t in_data,
    input  cpld_beat_pkg::tag_t  in_tag,
    input  cpld_beat_pkg::dcnt_t in_dcnt,
    cpld_stream_if.src           beat
);

    localparam int DW_NUM = `CPLD_DATA_W / 32;  // dwords per beat

    cpld_beat_pkg::data_t data_swap;

    // byte 3 of each dword lands in byte 0 and so on
    always_comb begin
        for (int d = 0; d < DW_NUM; d++) begin
            for (int b = 0; b < 4; b++) begin
                data_swap[d*32 + b*8 +: 8] = in_data[d*32 + (3-b)*8 +: 8];
            end
        end
    end

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            beat.sop  <= 1'b0;
            beat.eop  <= 1'b0;
            beat.dvld <= 1'b0;
            beat.data <= '0;
            beat.tag  <= '0;
            beat.dcnt <= '0;
        end else begin
            beat.sop  <= in_sop;
            beat.eop  <= in_eop;
            beat.dvld <= in_dvld;
            beat.data <= data_swap;
            beat.tag  <= in_tag;   // tag and count pass unchanged
            beat.dcnt <= in_dcnt;
        end
    end

    // a packet can only end on a valid beat
    a_eop_has_dvld : assert property (
        @(posedge PCIE_CLK) disable iff (PCIE_RST) in_eop |-> in_dvld
    );

endmodule

`default_nettype wire

// ==== hdl/cpld_tag_router.sv ====
// ==========================================================
// destination select of the cpld demultiplexer
// tag decode at each sop, held until the next sop
// ==========================================================

`default_nettype none

module cpld_tag_router (
    input  logic                      PCIE_CLK,
    input  logic                      PCIE_RST,
    input  logic                      in_sop,
    input  cpld_beat_pkg::tag_t       in_tag,
    output cpld_route_pkg::dest_sel_t dest_sel
);

    cpld_beat_pkg::cpld_tag_u  tag_view;
    cpld_route_pkg::dest_sel_t sel_next;
    logic                      sop_seen;  // set by the first sop after reset

    assign tag_view = in_tag;

    // ==========================================================
    // tag decode
    // ==========================================================

    always_comb begin
        sel_next = '0;
        if (tag_view.host_view.dpk) begin
            // 1Yxxxxxx
            if (tag_view.host_view.chan) begin
                sel_next[cpld_route_pkg::DPK_C1] = 1'b1;
            end else begin
                sel_next[cpld_route_pkg::DPK_C0] = 1'b1;
            end
        end else if (tag_view.kernel_view.dfk) begin
            // 0Y?1xxxx
            if (tag_view.kernel_view.chan) begin
                sel_next[cpld_route_pkg::DFK_C1] = 1'b1;
            end else begin
                sel_next[cpld_route_pkg::DFK_C0] = 1'b1;
            end
        end else begin
            // 0Y?0xxxx, write tags 0Y0xxxxx end up here as well
            if (tag_view.kernel_view.chan) begin
                sel_next[cpld_route_pkg::UEK_C1] = 1'b1;
            end else begin
                sel_next[cpld_route_pkg::UEK_C0] = 1'b1;
            end
        end
    end

    // ==========================================================
    // select register
    // ==========================================================

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            dest_sel <= '0;
            sop_seen <= 1'b0;
        end else if (in_sop) begin
            dest_sel <= sel_next;  // same edge as the swap register
            sop_seen <= 1'b1;
        end
    end

    a_sel_onehot : assert property (
        @(posedge PCIE_CLK) disable iff (PCIE_RST) sop_seen |-> $onehot(dest_sel)
    );

endmodule

`default_nettype wire

// ==== hdl/cpld_dest_port.sv ====
// ==========================================================
// output register set of one cpld destination
// ==========================================================

`default_nettype none

module cpld_dest_port (
    input  logic                  PCIE_CLK,
    input  logic                  PCIE_RST,
    input  logic                  sel,
    cpld_stream_if.sink           beat,
    output logic                  sop,
    output logic                  eop,
    output logic                  dvld,
    output cpld_beat_pkg::data_t  data,
    output cpld_beat_pkg::tag_t   tag,
    output cpld_beat_pkg::dcnt_t  dcnt
);

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            sop  <= 1'b0;
            eop  <= 1'b0;
            dvld <= 1'b0;
            data <= '0;
            tag  <= '0;
            dcnt <= '0;
        end else begin
            sop  <= beat.sop  & sel;  // strobes only for this destination
            eop  <= beat.eop  & sel;
            dvld <= beat.dvld & sel;
            data <= beat.data;        // fields go to every port
            tag  <= beat.tag;
            dcnt <= beat.dcnt;
        end
    end

    // a sop beat always reaches the port with valid data
    a_sop_with_dvld : assert property (
        @(posedge PCIE_CLK) disable iff (PCIE_RST) sop |-> dvld
    );

endmodule

`default_nettype wire

// ==== hdl/cpld_rx_demux.sv ====
// ==========================================================
// top level of the cpld receive demultiplexer
// swap stage, tag router and six destination ports
// ==========================================================

`default_nettype none

module cpld_rx_demux (
    input  logic                 PCIE_CLK,
    input  logic                 PCIE_RST,
    // ==========================================================
    // incoming completions
    // ==========================================================
    input  logic                 dn_cpld_sop,
    input  logic                 dn_cpld_eop,
    input  cpld_beat_pkg::data_t dn_cpld_data,
    input  logic                 dn_cpld_dvld,
    input  cpld_beat_pkg::tag_t  dn_cpld_tag,
    input  cpld_beat_pkg::dcnt_t dn_cpld_dcnt,
    // ==========================================================
    // destinations
    // ==========================================================
    output logic                 dfk_c0_sop, dfk_c0_eop, dfk_c0_dvld,
    output cpld_beat_pkg::data_t dfk_c0_data,
    output cpld_beat_pkg::tag_t  dfk_c0_tag,
    output cpld_beat_pkg::dcnt_t dfk_c0_dcnt,
    output logic                 dfk_c1_sop, dfk_c1_eop, dfk_c1_dvld,
    output cpld_beat_pkg::data_t dfk_c1_data,
    output cpld_beat_pkg::tag_t  dfk_c1_tag,
    output cpld_beat_pkg::dcnt_t dfk_c1_dcnt,
    output logic                 uek_c0_sop, uek_c0_eop, uek_c0_dvld,
    output cpld_beat_pkg::data_t uek_c0_data,
    output cpld_beat_pkg::tag_t  uek_c0_tag,
    output cpld_beat_pkg::dcnt_t uek_c0_dcnt,
    output logic                 uek_c1_sop, uek_c1_eop, uek_c1_dvld,
    output cpld_beat_pkg::data_t uek_c1_data,
    output cpld_beat_pkg::tag_t  uek_c1_tag,
    output cpld_beat_pkg::dcnt_t uek_c1_dcnt,
    output logic                 dpk_c0_sop, dpk_c0_eop, dpk_c0_dvld,
    output cpld_beat_pkg::data_t dpk_c0_data,
    output cpld_beat_pkg::tag_t  dpk_c0_tag,
    output cpld_beat_pkg::dcnt_t dpk_c0_dcnt,
    output logic                 dpk_c1_sop, dpk_c1_eop, dpk_c1_dvld,
    output cpld_beat_pkg::data_t dpk_c1_data,
    output cpld_beat_pkg::tag_t  dpk_c1_tag,
    output cpld_beat_pkg::dcnt_t dpk_c1_dcnt
);

    cpld_route_pkg::dest_sel_t dest_sel;  // latched at sop
    cpld_stream_if             beat_if ();

    cpld_dword_swap u_swap (
        .PCIE_CLK (PCIE_CLK),     .PCIE_RST (PCIE_RST),
        .in_sop   (dn_cpld_sop),  .in_eop   (dn_cpld_eop),  .in_dvld (dn_cpld_dvld),
        .in_data  (dn_cpld_data), .in_tag   (dn_cpld_tag),  .in_dcnt (dn_cpld_dcnt),
        .beat     (beat_if)
    );

    // decodes the raw tag so the select is ready with the swapped beat
    cpld_tag_router u_router (
        .PCIE_CLK (PCIE_CLK), .PCIE_RST (PCIE_RST),
        .in_sop   (dn_cpld_sop), .in_tag (dn_cpld_tag),
        .dest_sel (dest_sel)
    );

    // ==========================================================
    // destination ports
    // ==========================================================

    cpld_dest_port u_dfk_c0 (
        .PCIE_CLK (PCIE_CLK), .PCIE_RST (PCIE_RST), .beat (beat_if),
        .sel  (dest_sel[cpld_route_pkg::DFK_C0]),
        .sop  (dfk_c0_sop),  .eop (dfk_c0_eop), .dvld (dfk_c0_dvld),
        .data (dfk_c0_data), .tag (dfk_c0_tag), .dcnt (dfk_c0_dcnt)
    );

    cpld_dest_port u_dfk_c1 (
        .PCIE_CLK (PCIE_CLK), .PCIE_RST (PCIE_RST), .beat (beat_if),
        .sel  (dest_sel[cpld_route_pkg::DFK_C1]),
        .sop  (dfk_c1_sop),  .eop (dfk_c1_eop), .dvld (dfk_c1_dvld),
        .data (dfk_c1_data), .tag (dfk_c1_tag), .dcnt (dfk_c1_dcnt)
    );

    cpld_dest_port u_uek_c0 (
        .PCIE_CLK (PCIE_CLK), .PCIE_RST (PCIE_RST), .beat (beat_if),
        .sel  (dest_sel[cpld_route_pkg::UEK_C0]),
        .sop  (uek_c0_sop),  .eop (uek_c0_eop), .dvld (uek_c0_dvld),
        .data (uek_c0_data), .tag (uek_c0_tag), .dcnt (uek_c0_dcnt)
    );

    cpld_dest_port u_uek_c1 (
        .PCIE_CLK (PCIE_CLK), .PCIE_RST (PCIE_RST), .beat (beat_if),
        .sel  (dest_sel[cpld_route_pkg::UEK_C1]),
        .sop  (uek_c1_sop),  .eop (uek_c1_eop), .dvld (uek_c1_dvld),
        .data (uek_c1_data), .tag (uek_c1_tag), .dcnt (uek_c1_dcnt)
    );

    cpld_dest_port u_dpk_c0 (
        .PCIE_CLK (PCIE_CLK), .PCIE_RST (PCIE_RST), .beat (beat_if),
        .sel  (dest_sel[cpld_route_pkg::DPK_C0]),
        .sop  (dpk_c0_sop),  .eop (dpk_c0_eop), .dvld (dpk_c0_dvld),
        .data (dpk_c0_data), .tag (dpk_c0_tag), .dcnt (dpk_c0_dcnt)
    );

    cpld_dest_port u_dpk_c1 (
        .PCIE_CLK (PCIE_CLK), .PCIE_RST (PCIE_RST), .beat (beat_if),
        .sel  (dest_sel[cpld_route_pkg::DPK_C1]),
        .sop  (dpk_c1_sop),  .eop (dpk_c1_eop), .dvld (dpk_c1_dvld),
        .data (dpk_c1_data), .tag (dpk_c1_tag), .dcnt (dpk_c1_dcnt)
    );

endmodule

`default_nettype wire

// ==== sim/cpld_rx_checker.sv ====
// ==========================================================
// reference model and output compare of the cpld demux
// per-test report lines and the closing count line
// ==========================================================

`default_nettype none

`include "cpld_rx_config.svh"

module cpld_rx_checker (
    input  logic                                        PCIE_CLK,
    input  logic                                        PCIE_RST,
    input  logic                                        dn_cpld_sop, dn_cpld_eop, dn_cpld_dvld,
    input  logic [`CPLD_DATA_W-1:0]                     dn_cpld_data,
    input  logic [`CPLD_TAG_W-1:0]                      dn_cpld_tag,
    input  logic [`CPLD_DCNT_W-1:0]                     dn_cpld_dcnt,
    input  logic [`CPLD_DEST_NUM-1:0]                   dst_sop, dst_eop, dst_dvld,
    input  logic [`CPLD_DEST_NUM-1:0][`CPLD_DATA_W-1:0] dst_data,
    input  logic [`CPLD_DEST_NUM-1:0][`CPLD_TAG_W-1:0]  dst_tag,
    input  logic [`CPLD_DEST_NUM-1:0][`CPLD_DCNT_W-1:0] dst_dcnt,
    input  int                                          test_num,
    input  logic                                        test_end, all_done,
    output bit                                          report_done,
    output int                                          fail_cnt
);

    typedef struct packed {
        logic                    sop;
        logic                    eop;
        logic                    dvld;
        logic [`CPLD_DATA_W-1:0] data;
        logic [`CPLD_TAG_W-1:0]  tag;
        logic [`CPLD_DCNT_W-1:0] dcnt;
    } beat_t;

    beat_t                     stage1, stage2;  // swap register, port register
    logic [`CPLD_DEST_NUM-1:0] sel1, sel2;      // select at sop, select seen by the ports
    int                        pass_cnt;
    int                        test_err;        // mismatches in the running test

    string dest_name [`CPLD_DEST_NUM] = '{"dfk_c0", "dfk_c1", "uek_c0", "uek_c1",
                                          "dpk_c0", "dpk_c1"};
    string test_title [1:6] = '{"reset values", "data swap and fields", "dpk routing",
                                "dfk and uek routing", "mid-packet hold", "back-to-back switch"};

    // bytes reversed inside each dword
    function automatic logic [`CPLD_DATA_W-1:0] swap_bytes(input logic [`CPLD_DATA_W-1:0] d);
        return {d[39:32], d[47:40], d[55:48], d[63:56], d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    function automatic cpld_route_pkg::dest_e route_of(input logic [`CPLD_TAG_W-1:0] tag);
        if (tag[7]) begin
            return tag[6] ? cpld_route_pkg::DPK_C1 : cpld_route_pkg::DPK_C0;
        end
        if (tag[4]) begin
            return tag[6] ? cpld_route_pkg::DFK_C1 : cpld_route_pkg::DFK_C0;
        end
        return tag[6] ? cpld_route_pkg::UEK_C1 : cpld_route_pkg::UEK_C0;  // bit 5 plays no part
    endfunction

    task automatic check_value(input int d, input string field,
                               input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s_%s got %h expected %h",
                     $time, dest_name[d], field, got, exp);
            test_err++;
        end
    endtask

    // ==========================================================
    // model pipeline
    // ==========================================================

    always @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            stage1 <= '0;
            stage2 <= '0;
            sel1   <= '0;
            sel2   <= '0;
        end else begin
            stage1 <= {dn_cpld_sop, dn_cpld_eop, dn_cpld_dvld, swap_bytes(dn_cpld_data),
                       dn_cpld_tag, dn_cpld_dcnt};
            stage2 <= stage1;
            sel2   <= sel1;
            if (dn_cpld_sop) begin
                sel1                       <= '0;
                sel1[route_of(dn_cpld_tag)] <= 1'b1;  // raw tag, same edge as stage1
            end
        end
    end

    // ==========================================================
    // compare and report, half a cycle after the outputs settle
    // ==========================================================

    always @(negedge PCIE_CLK) begin
        if (!PCIE_RST) begin
            for (int d = 0; d < `CPLD_DEST_NUM; d++) begin
                check_value(d, "sop", 64'(dst_sop[d]), 64'(stage2.sop & sel2[d]));
                check_value(d, "eop", 64'(dst_eop[d]), 64'(stage2.eop & sel2[d]));
                check_value(d, "dvld", 64'(dst_dvld[d]), 64'(stage2.dvld & sel2[d]));
                check_value(d, "data", dst_data[d], stage2.data);
                check_value(d, "tag", 64'(dst_tag[d]), 64'(stage2.tag));
                check_value(d, "dcnt", 64'(dst_dcnt[d]), 64'(stage2.dcnt));
            end
        end
        if (test_end) begin
            if (test_err == 0) begin
                $display("test %0d %s: pass", test_num, test_title[test_num]);
                pass_cnt++;
            end else begin
                $display("test %0d %s: fail, %0d mismatches",
                         test_num, test_title[test_num], test_err);
                fail_cnt++;
            end
            test_err = 0;
        end
        if (all_done && !report_done) begin
            $display("%0d tests run, %0d passed, %0d failed",
                     pass_cnt + fail_cnt, pass_cnt, fail_cnt);
            report_done = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_cpld_rx_demux.sv ====
// ==========================================================
// testbench of the cpld receive demultiplexer
// clock, reset, lfsr stimulus, watchdog and the checker
// ==========================================================

`default_nettype none

`include "cpld_rx_config.svh"

module tb_cpld_rx_demux;

    localparam int PKTS        = 40;  // packets per routing test
    localparam int TOTAL_BEATS = 30 + 5 * (PKTS * 11 + 4);  // 8 beats and 3 idle at most

    logic                                        PCIE_CLK = 1'b0;
    logic                                        PCIE_RST = 1'b1;
    logic                                        dn_cpld_sop = 1'b0;
    logic                                        dn_cpld_eop = 1'b0;
    logic                                        dn_cpld_dvld = 1'b0;
    logic [`CPLD_DATA_W-1:0]                     dn_cpld_data = '0;
    logic [`CPLD_TAG_W-1:0]                      dn_cpld_tag = '0;
    logic [`CPLD_DCNT_W-1:0]                     dn_cpld_dcnt = '0;
    logic [`CPLD_DEST_NUM-1:0]                   dst_sop, dst_eop, dst_dvld;
    logic [`CPLD_DEST_NUM-1:0][`CPLD_DATA_W-1:0] dst_data;
    logic [`CPLD_DEST_NUM-1:0][`CPLD_TAG_W-1:0]  dst_tag;
    logic [`CPLD_DEST_NUM-1:0][`CPLD_DCNT_W-1:0] dst_dcnt;
    int                                          test_num = 0;
    logic                                        test_end = 1'b0;
    logic                                        all_done = 1'b0;
    bit                                          report_done;
    int                                          fail_cnt;
    logic [31:0]                                 lfsr_state = 32'h77091ad9;

    always #5 PCIE_CLK = ~PCIE_CLK;

    cpld_rx_demux UUT (
        .*,
        .dfk_c0_sop  (dst_sop[cpld_route_pkg::DFK_C0]), .dfk_c0_eop (dst_eop[cpld_route_pkg::DFK_C0]),
        .dfk_c0_dvld (dst_dvld[cpld_route_pkg::DFK_C0]), .dfk_c0_data (dst_data[cpld_route_pkg::DFK_C0]),
        .dfk_c0_tag  (dst_tag[cpld_route_pkg::DFK_C0]), .dfk_c0_dcnt (dst_dcnt[cpld_route_pkg::DFK_C0]),
        .dfk_c1_sop  (dst_sop[cpld_route_pkg::DFK_C1]), .dfk_c1_eop (dst_eop[cpld_route_pkg::DFK_C1]),
        .dfk_c1_dvld (dst_dvld[cpld_route_pkg::DFK_C1]), .dfk_c1_data (dst_data[cpld_route_pkg::DFK_C1]),
        .dfk_c1_tag  (dst_tag[cpld_route_pkg::DFK_C1]), .dfk_c1_dcnt (dst_dcnt[cpld_route_pkg::DFK_C1]),
        .uek_c0_sop  (dst_sop[cpld_route_pkg::UEK_C0]), .uek_c0_eop (dst_eop[cpld_route_pkg::UEK_C0]),
        .uek_c0_dvld (dst_dvld[cpld_route_pkg::UEK_C0]), .uek_c0_data (dst_data[cpld_route_pkg::UEK_C0]),
        .uek_c0_tag  (dst_tag[cpld_route_pkg::UEK_C0]), .uek_c0_dcnt (dst_dcnt[cpld_route_pkg::UEK_C0]),
        .uek_c1_sop  (dst_sop[cpld_route_pkg::UEK_C1]), .uek_c1_eop (dst_eop[cpld_route_pkg::UEK_C1]),
        .uek_c1_dvld (dst_dvld[cpld_route_pkg::UEK_C1]), .uek_c1_data (dst_data[cpld_route_pkg::UEK_C1]),
        .uek_c1_tag  (dst_tag[cpld_route_pkg::UEK_C1]), .uek_c1_dcnt (dst_dcnt[cpld_route_pkg::UEK_C1]),
        .dpk_c0_sop  (dst_sop[cpld_route_pkg::DPK_C0]), .dpk_c0_eop (dst_eop[cpld_route_pkg::DPK_C0]),
        .dpk_c0_dvld (dst_dvld[cpld_route_pkg::DPK_C0]), .dpk_c0_data (dst_data[cpld_route_pkg::DPK_C0]),
        .dpk_c0_tag  (dst_tag[cpld_route_pkg::DPK_C0]), .dpk_c0_dcnt (dst_dcnt[cpld_route_pkg::DPK_C0]),
        .dpk_c1_sop  (dst_sop[cpld_route_pkg::DPK_C1]), .dpk_c1_eop (dst_eop[cpld_route_pkg::DPK_C1]),
        .dpk_c1_dvld (dst_dvld[cpld_route_pkg::DPK_C1]), .dpk_c1_data (dst_data[cpld_route_pkg::DPK_C1]),
        .dpk_c1_tag  (dst_tag[cpld_route_pkg::DPK_C1]), .dpk_c1_dcnt (dst_dcnt[cpld_route_pkg::DPK_C1])
    );

    cpld_rx_checker chk (.*);

    // ==========================================================
    // random bits
    // ==========================================================

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r          = {r[62:0], lfsr_state[0]};  // one step per bit
        end
        return r;
    endfunction

    // ==========================================================
    // stimulus
    // ==========================================================

    task automatic drive_beat(input logic sop, input logic eop, input logic [`CPLD_TAG_W-1:0] tag);
        logic [63:0] bits;
        @(posedge PCIE_CLK);
        #1;
        dn_cpld_sop  = sop;
        dn_cpld_eop  = eop;
        dn_cpld_dvld = 1'b1;  // every packet beat carries data
        dn_cpld_data = take_bits(`CPLD_DATA_W);
        dn_cpld_tag  = tag;
        bits         = take_bits(`CPLD_DCNT_W);
        dn_cpld_dcnt = bits[`CPLD_DCNT_W-1:0];
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge PCIE_CLK);
            #1;
            dn_cpld_sop  = 1'b0;
            dn_cpld_eop  = 1'b0;
            dn_cpld_dvld = 1'b0;
        end
    endtask

    task automatic finish_test();
        idle_cycles(3);  // drain the two stage pipeline
        test_end = 1'b1;
        @(posedge PCIE_CLK);
        #1;
        test_end = 1'b0;
    endtask

    // tag_mode 1 forces bit 7 high, 2 forces it low
    task automatic run_test(input int num, input int tag_mode, input bit gaps, input bit mid_tag);
        logic [63:0]            bits;
        logic [`CPLD_TAG_W-1:0] tag;
        logic [`CPLD_TAG_W-1:0] beat_tag;
        int                     len;
        int                     gap;
        test_num = num;
        for (int p = 0; p < PKTS; p++) begin
            bits = take_bits(`CPLD_TAG_W);
            tag  = bits[`CPLD_TAG_W-1:0];
            if (tag_mode == 1) tag[7] = 1'b1;
            if (tag_mode == 2) tag[7] = 1'b0;
            len = 1 + int'(take_bits(3));
            gap = gaps ? int'(take_bits(2)) : 0;
            if (mid_tag && len < 2) len = 2;
            for (int b = 0; b < len; b++) begin
                beat_tag = tag;
                if (mid_tag && b > 0) begin
                    bits     = take_bits(`CPLD_TAG_W);  // must not move the strobes
                    beat_tag = bits[`CPLD_TAG_W-1:0];
                end
                drive_beat(b == 0, b == len - 1, beat_tag);
            end
            idle_cycles(gap);
        end
        finish_test();
    endtask

    // ==========================================================
    // sequence and watchdog
    // ==========================================================

    initial begin
        repeat (10) @(posedge PCIE_CLK);
        #1;
        PCIE_RST = 1'b0;
        test_num = 1;
        idle_cycles(4);
        repeat (4) drive_beat(1'b0, 1'b0, 8'h00);  // no sop yet, no destination
        finish_test();
        run_test(2, 0, 1'b1, 1'b0);
        run_test(3, 1, 1'b1, 1'b0);
        run_test(4, 2, 1'b1, 1'b0);
        run_test(5, 0, 1'b1, 1'b1);
        run_test(6, 0, 1'b0, 1'b0);
        all_done = 1'b1;
        wait (report_done);
        if (fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_BEATS * 10 * 2);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpld_rx_demux.f ====
+incdir+hdl
hdl/cpld_beat_pkg.sv
hdl/cpld_route_pkg.sv
hdl/cpld_stream_if.sv
hdl/cpld_dword_swap.sv
hdl/cpld_tag_router.sv
hdl/cpld_dest_port.sv
hdl/cpld_rx_demux.sv
sim/cpld_rx_checker.sv
sim/tb_cpld_rx_demux.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cpld demultiplexer testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module tb_cpld_rx_demux -f cpld_rx_demux.f

./obj_dir/Vtb_cpld_rx_demux > sim.log
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
